/* logic/armIsaPkg.sv */
package armIsaPkg;

  localparam int InstrWidth = 32;  // Fixed ARM word

  // =========================================================================
  // Field positions
  // =========================================================================
  localparam int CondMsb     = 31;
  localparam int CondLsb     = 28;
  localparam int ClassMsb    = 27;  // Major class bits 27:25
  localparam int ClassLsb    = 25;
  localparam int IBit        = 25;  // Immediate / register offset select
  localparam int OpMsb       = 24;  // DP opcode
  localparam int OpLsb       = 21;
  localparam int UBit        = 23;  // Offset up / down
  localparam int BBit        = 22;  // Byte / word
  localparam int LBit        = 20;  // Load / store
  localparam int SBit        = 20;  // Set flags, same slot as L
  localparam int RdMsb       = 15;
  localparam int RdLsb       = 12;
  localparam int ShiftRegBit = 4;   // Set for reg-shifted-reg and extra encodings

  localparam logic [3:0] PcIndex   = 4'hF;  // R15
  localparam logic [3:0] CondNever = 4'hF;  // Unused in this core

  // Condition field
  typedef enum logic [3:0] {
    condEq, condNe, condCs, condCc, condMi, condPl, condVs, condVc,
    condHi, condLs, condGe, condLt, condGt, condLe, condAl
  } condCode_t;

  // Data processing opcodes, bits 24:21
  typedef enum logic [3:0] {
    aluAnd, aluEor, aluSub, aluRsb, aluAdd, aluAdc, aluSbc, aluRsc,
    aluTst, aluTeq, aluCmp, aluCmn, aluOrr, aluMov, aluBic, aluMvn
  } aluOp_t;

  typedef enum logic [2:0] {
    dataReg, dataImm, loadStore, branch, unsupported
  } instrClass_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

endpackage

/* logic/ctrlPkg.sv */
package ctrlPkg;

  localparam int ByteLanes = 4;  // Lanes per data word

  // Decoded word, Decode into Execute
  typedef struct packed {
    armIsaPkg::condCode_t condition;
    logic                 aluSrc;      // 1 = immediate operand B
    armIsaPkg::aluOp_t    aluControl;
    logic                 setFlags;    // S bit
    logic                 branch;
    logic                 regWrite;
    logic                 memWrite;
    logic                 memtoReg;
    logic                 pcSrc;       // Writes R15
    logic                 byteAccess;  // LDRB / STRB
  } execCtrl_t;

  // Condition-gated word, Execute into Memory
  typedef struct packed {
    logic             regWrite;
    logic             memWrite;
    logic             memtoReg;
    logic             pcSrc;
    logic             byteAccess;
    logic [1:0]       byteOffset;  // Low address bits
    logic             setFlags;
    armIsaPkg::nzcv_t flagsNext;
  } memCtrl_t;

  // Writeback outputs
  typedef struct packed {
    logic             regWrite;
    logic             memtoReg;
    logic             pcSrc;
    logic             loadByte;    // Byte load, datapath picks the lane
    logic [1:0]       byteOffset;
    logic             setFlags;
    armIsaPkg::nzcv_t flagsNext;
  } wbCtrl_t;

  typedef struct packed {
    logic [1:0] regSrc;
    logic [1:0] immSrc;
  } decodeOut_t;

endpackage

/* logic/instrDecoder.sv */
module instrDecoder (
  input  logic [armIsaPkg::InstrWidth-1:0] instrD,
  output ctrlPkg::decodeOut_t              decodeD,
  output ctrlPkg::execCtrl_t               ctrlD
);
  import armIsaPkg::*;

  instrClass_t instrClass;
  logic [3:0]  opcode;
  logic        compareOp;  // TST TEQ CMP CMN
  logic        miscSpace;  // Compare opcodes without S hold MSR, MRS, BX
  logic        loadOp;

  assign opcode    = instrD[OpMsb:OpLsb];
  assign compareOp = (opcode[3:2] == 2'b10);
  assign miscSpace = compareOp && !instrD[SBit];
  assign loadOp    = instrD[LBit];

  // =========================================================================
  // Classification
  // =========================================================================
  always_comb begin : classify
    instrClass = unsupported;
    case (instrD[ClassMsb:ClassLsb])
      3'b000: if (!instrD[ShiftRegBit] && !miscSpace) instrClass = dataReg;  // No mul, halfword
      3'b001: if (!miscSpace) instrClass = dataImm;
      3'b010: instrClass = loadStore;  // Immediate offset
      3'b011: if (!instrD[ShiftRegBit]) instrClass = loadStore;  // Register offset
      3'b101: instrClass = branch;
      default: instrClass = unsupported;  // LDM/STM, coproc, SWI
    endcase
    if (instrD[CondMsb:CondLsb] == CondNever) begin
      instrClass = unsupported;
    end
  end

  // =========================================================================
  // Control word
  // =========================================================================
  always_comb begin : fill
    ctrlD   = '0;
    decodeD = '0;
    case (instrClass)
      dataReg, dataImm: begin
        ctrlD.aluSrc     = (instrClass == dataImm);
        ctrlD.aluControl = aluOp_t'(opcode);
        ctrlD.setFlags   = instrD[SBit];
        ctrlD.regWrite   = !compareOp;  // Compares only touch flags
      end
      loadStore: begin
        ctrlD.aluSrc     = !instrD[IBit];  // I clear means 12-bit immediate
        ctrlD.aluControl = instrD[UBit] ? aluAdd : aluSub;
        ctrlD.byteAccess = instrD[BBit];
        ctrlD.regWrite   = loadOp;
        ctrlD.memtoReg   = loadOp;
        ctrlD.memWrite   = !loadOp;
        decodeD.regSrc   = {!loadOp, 1'b0};  // Store reads Rd as data
        decodeD.immSrc   = 2'b01;
      end
      branch: begin
        ctrlD.aluSrc     = 1'b1;
        ctrlD.aluControl = aluAdd;  // PC + offset
        ctrlD.branch     = 1'b1;
        decodeD.regSrc   = 2'b01;  // Base is PC
        decodeD.immSrc   = 2'b10;
      end
      default: ;  // Cleared word
    endcase
    if (instrClass != unsupported) begin
      ctrlD.condition = condCode_t'(instrD[CondMsb:CondLsb]);
    end
    // Branch or any write to R15 redirects fetch
    ctrlD.pcSrc = ctrlD.branch || (ctrlD.regWrite && instrD[RdMsb:RdLsb] == PcIndex);
  end

  // Memory and register ports never fire for one instruction
  always_comb begin : exclusiveWrite
    assert (!(ctrlD.memWrite && ctrlD.regWrite))
      else $error("decoder raised memWrite and regWrite together");
  end

endmodule

/* logic/condCheck.sv */
module condCheck (
  input  armIsaPkg::condCode_t cond,
  input  armIsaPkg::nzcv_t     flagsE,     // Forwarded NZCV
  input  armIsaPkg::nzcv_t     aluFlagsE,  // Flags from this ALU op
  input  logic                 setFlags,
  output logic                 condEx,
  output armIsaPkg::nzcv_t     flagsNext
);
  import armIsaPkg::*;

  logic n;
  logic z;
  logic c;
  logic v;

  assign n = flagsE.n;
  assign z = flagsE.z;
  assign c = flagsE.c;
  assign v = flagsE.v;

  // =========================================================================
  // ARM condition table
  // =========================================================================
  always_comb begin
    case (cond)
      condEq:  condEx = z;
      condNe:  condEx = !z;
      condCs:  condEx = c;
      condCc:  condEx = !c;
      condMi:  condEx = n;
      condPl:  condEx = !n;
      condVs:  condEx = v;
      condVc:  condEx = !v;
      condHi:  condEx = c && !z;         // Unsigned higher
      condLs:  condEx = !c || z;
      condGe:  condEx = (n == v);        // Signed
      condLt:  condEx = (n != v);
      condGt:  condEx = !z && (n == v);
      condLe:  condEx = z || (n != v);
      condAl:  condEx = 1'b1;
      default: condEx = 1'b0;            // NV slot
    endcase
  end

  // Flags move only for an executed S instruction
  assign flagsNext = (setFlags && condEx) ? aluFlagsE : flagsE;

endmodule

/* logic/execStage.sv */
module execStage (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             stallE,
  input  logic                             flushE,
  input  ctrlPkg::execCtrl_t               ctrlD,
  input  armIsaPkg::nzcv_t                 flagsE,
  input  armIsaPkg::nzcv_t                 aluFlagsE,
  input  logic [1:0]                       aluResultLowE,  // Address bits 1:0
  output logic                             aluSrcE,
  output armIsaPkg::aluOp_t                aluControlE,
  output logic                             branchTakenE,
  output logic                             pcSrcE,         // Ungated, for hazard side
  output ctrlPkg::memCtrl_t                ctrlM,
  output logic [ctrlPkg::ByteLanes-1:0]    byteMaskE
);
  import armIsaPkg::*;
  import ctrlPkg::*;

  execCtrl_t ctrlE;
  nzcv_t     flagsNextE;
  logic      condEx;

  // =========================================================================
  // Execute register
  // =========================================================================
  always_ff @(posedge clk) begin
    if (!rstN) begin
      ctrlE <= '0;
    end else if (!stallE) begin
      ctrlE <= flushE ? '0 : ctrlD;  // Bubble on flush
    end
  end

  condCheck condUnit (
    .cond      (ctrlE.condition),
    .flagsE    (flagsE),
    .aluFlagsE (aluFlagsE),
    .setFlags  (ctrlE.setFlags),
    .condEx    (condEx),
    .flagsNext (flagsNextE)
  );

  assign aluSrcE      = ctrlE.aluSrc;
  assign aluControlE  = ctrlE.aluControl;
  assign branchTakenE = ctrlE.branch && condEx;
  assign pcSrcE       = ctrlE.pcSrc;

  // Store lanes, only for an executed store
  always_comb begin
    byteMaskE = '0;
    if (ctrlE.memWrite && condEx) begin
      if (ctrlE.byteAccess) begin
        byteMaskE[aluResultLowE] = 1'b1;  // STRB hits one lane
      end else begin
        byteMaskE = '1;                   // STR writes the whole word
      end
    end
  end

  // Side effects gated by the condition result
  always_comb begin
    ctrlM            = '0;
    ctrlM.regWrite   = ctrlE.regWrite && condEx;
    ctrlM.memWrite   = ctrlE.memWrite && condEx;
    ctrlM.memtoReg   = ctrlE.memtoReg;
    ctrlM.pcSrc      = ctrlE.pcSrc && condEx;
    ctrlM.byteAccess = ctrlE.byteAccess;
    ctrlM.byteOffset = aluResultLowE;
    ctrlM.setFlags   = ctrlE.setFlags && condEx;
    ctrlM.flagsNext  = flagsNextE;
  end

  // Byte store leaves Execute with exactly one lane
  assert property (@(posedge clk) disable iff (!rstN)
    (ctrlM.memWrite && ctrlM.byteAccess) |-> $onehot(byteMaskE))
    else $error("byte store mask 0x%h is not one-hot", byteMaskE);

endmodule

/* logic/memWbStages.sv */
module memWbStages (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             stallM,
  input  logic                             stallW,
  input  logic                             flushW,
  input  ctrlPkg::memCtrl_t                ctrlM,      // Execute result
  input  logic [ctrlPkg::ByteLanes-1:0]    byteMaskE,
  output logic                             memWriteM,
  output logic [ctrlPkg::ByteLanes-1:0]    byteMaskM,
  output logic                             pcSrcM,
  output logic                             setFlagsM,
  output armIsaPkg::nzcv_t                 flagsNextM,
  output ctrlPkg::wbCtrl_t                 wbW
);
  import ctrlPkg::*;

  memCtrl_t memQ;
  wbCtrl_t  wbNext;

  // =========================================================================
  // Memory register with stall and no flush
  // =========================================================================
  always_ff @(posedge clk) begin
    if (!rstN) begin
      memQ      <= '0;
      byteMaskM <= '0;
    end else if (!stallM) begin
      memQ      <= ctrlM;
      byteMaskM <= byteMaskE;
    end
  end

  assign memWriteM  = memQ.memWrite;
  assign pcSrcM     = memQ.pcSrc;
  assign setFlagsM  = memQ.setFlags;
  assign flagsNextM = memQ.flagsNext;

  always_comb begin
    wbNext.regWrite   = memQ.regWrite;
    wbNext.memtoReg   = memQ.memtoReg;
    wbNext.pcSrc      = memQ.pcSrc;
    wbNext.loadByte   = memQ.byteAccess && memQ.memtoReg;  // LDRB
    wbNext.byteOffset = memQ.byteOffset;
    wbNext.setFlags   = memQ.setFlags;
    wbNext.flagsNext  = memQ.flagsNext;
  end

  // Writeback register
  always_ff @(posedge clk) begin
    if (!rstN) begin
      wbW <= '0;
    end else if (!stallW) begin
      wbW <= flushW ? '0 : wbNext;
    end
  end

  // Flushed instruction never reaches the register file
  assert property (@(posedge clk) disable iff (!rstN)
    (flushW && !stallW) |=> !wbW.regWrite)
    else $error("regWrite in Writeback after flushW");

endmodule

/* logic/flagReg.sv */
module flagReg #(
  parameter logic [3:0] ResetFlags = 4'h0
) (
  input  logic              clk,
  input  logic              rstN,
  input  logic              stallW,
  input  logic              setFlagsM,
  input  armIsaPkg::nzcv_t  flagsNextM,
  input  ctrlPkg::wbCtrl_t  wbW,
  output armIsaPkg::nzcv_t  flagsE,  // To condition check
  output armIsaPkg::nzcv_t  flags    // Architectural NZCV
);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= ResetFlags;
    end else if (wbW.setFlags && !stallW) begin
      flags <= wbW.flagsNext;  // Commit in Writeback
    end
  end

  // Youngest pending writer wins
  assign flagsE = setFlagsM    ? flagsNextM :
                  wbW.setFlags ? wbW.flagsNext :
                                 flags;

endmodule

/* logic/ctrlTop.sv */
module ctrlTop #(
  parameter logic [3:0] ResetFlags = 4'h0
) (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic [armIsaPkg::InstrWidth-1:0] instrD,
  input  armIsaPkg::nzcv_t                 aluFlagsE,
  input  logic [1:0]                       aluResultLowE,
  input  logic                             stallE,
  input  logic                             flushE,
  input  logic                             stallM,
  input  logic                             stallW,
  input  logic                             flushW,
  output ctrlPkg::decodeOut_t              decodeD,
  output logic                             aluSrcE,
  output armIsaPkg::aluOp_t                aluControlE,
  output logic                             branchTakenE,
  output logic                             memWriteM,
  output logic [3:0]                       byteMaskM,
  output ctrlPkg::wbCtrl_t                 wbW,
  output armIsaPkg::nzcv_t                 flags,
  output logic                             pcWrPending
);
  import armIsaPkg::*;
  import ctrlPkg::*;

  execCtrl_t             ctrlD;
  memCtrl_t              ctrlM;
  nzcv_t                 flagsE;
  nzcv_t                 flagsNextM;
  logic [ByteLanes-1:0]  byteMaskE;
  logic                  pcSrcE;
  logic                  pcSrcM;
  logic                  setFlagsM;

  // =========================================================================
  // Decode to Writeback
  // =========================================================================
  instrDecoder decoder (
    .instrD  (instrD),
    .decodeD (decodeD),
    .ctrlD   (ctrlD)
  );

  execStage execute (
    .clk           (clk),
    .rstN          (rstN),
    .stallE        (stallE),
    .flushE        (flushE),
    .ctrlD         (ctrlD),
    .flagsE        (flagsE),
    .aluFlagsE     (aluFlagsE),
    .aluResultLowE (aluResultLowE),
    .aluSrcE       (aluSrcE),
    .aluControlE   (aluControlE),
    .branchTakenE  (branchTakenE),
    .pcSrcE        (pcSrcE),
    .ctrlM         (ctrlM),
    .byteMaskE     (byteMaskE)
  );

  memWbStages memWb (
    .clk        (clk),
    .rstN       (rstN),
    .stallM     (stallM),
    .stallW     (stallW),
    .flushW     (flushW),
    .ctrlM      (ctrlM),
    .byteMaskE  (byteMaskE),
    .memWriteM  (memWriteM),
    .byteMaskM  (byteMaskM),
    .pcSrcM     (pcSrcM),
    .setFlagsM  (setFlagsM),
    .flagsNextM (flagsNextM),
    .wbW        (wbW)
  );

  flagReg #(
    .ResetFlags (ResetFlags)
  ) status (
    .clk        (clk),
    .rstN       (rstN),
    .stallW     (stallW),
    .setFlagsM  (setFlagsM),
    .flagsNextM (flagsNextM),
    .wbW        (wbW),
    .flagsE     (flagsE),
    .flags      (flags)
  );

  assign pcWrPending = ctrlD.pcSrc || pcSrcE || pcSrcM;  // Hold fetch until PC settles

endmodule

/* tests/tbClock.sv */
module tbClock #(
  parameter int PeriodNs = 4
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  // Free-running clock, low at time zero
  initial begin
    clk = 1'b0;
    forever #(PeriodNs / 2.0) clk = ~clk;  // Half period per toggle
  end

endmodule

/* tests/ctrlTb.sv */
module ctrlTb;
  timeunit 1ns;
  timeprecision 100ps;
  import armIsaPkg::*;
  import ctrlPkg::*;

  localparam logic [3:0]  ResetFlags = 4'h6;            // Z and C out of reset
  localparam int          ClkPeriod  = 4;
  localparam logic [31:0] NopInstr   = 32'hF000_0000;   // NV space, cleared word

  // One cycle of stimulus plus the static expectations of its instruction
  typedef struct packed {
    logic [31:0] instr;
    logic [3:0]  aluFlags;     // ALU result flags while in Execute
    logic [1:0]  offset;       // Low address bits while in Execute
    logic        stallE;
    logic        flushE;
    logic        stallM;
    logic        stallW;
    logic        flushW;
    logic [3:0]  expDecode;    // {regSrc, immSrc}
    logic [3:0]  expAluCtrl;
    logic        expAluSrc;
    logic        expBranch;
    logic        expRegWrite;  // Before condition gating
    logic        expMemWrite;
    logic        expPcSrc;
    logic        expSetFlags;
    logic        expByte;
  } row_t;

  // Which row a stage register holds
  typedef struct packed {
    logic       valid;
    logic [7:0] idx;
    logic       pass;       // Condition result seen in Execute
    logic [3:0] newFlags;   // Flags it carries onward
  } slot_t;

  logic                  clk;
  logic                  rstN;
  logic [InstrWidth-1:0] instrD;
  nzcv_t                 aluFlagsE;
  logic [1:0]            aluResultLowE;
  logic                  stallE;
  logic                  flushE;
  logic                  stallM;
  logic                  stallW;
  logic                  flushW;
  decodeOut_t            decodeD;
  logic                  aluSrcE;
  aluOp_t                aluControlE;
  logic                  branchTakenE;
  logic                  memWriteM;
  logic [3:0]            byteMaskM;
  wbCtrl_t               wbW;
  nzcv_t                 flags;
  logic                  pcWrPending;

  row_t       rows[$];
  slot_t      eSlot;
  slot_t      mSlot;
  slot_t      wSlot;
  logic [3:0] expFlags;    // Committed NZCV
  logic       tableReady;
  int         checks;
  int         errors;

  tbClock #(.PeriodNs(ClkPeriod)) clockGen (.clk(clk));

  ctrlTop #(.ResetFlags(ResetFlags)) i_dut (
    .clk           (clk),
    .rstN          (rstN),
    .instrD        (instrD),
    .aluFlagsE     (aluFlagsE),
    .aluResultLowE (aluResultLowE),
    .stallE        (stallE),
    .flushE        (flushE),
    .stallM        (stallM),
    .stallW        (stallW),
    .flushW        (flushW),
    .decodeD       (decodeD),
    .aluSrcE       (aluSrcE),
    .aluControlE   (aluControlE),
    .branchTakenE  (branchTakenE),
    .memWriteM     (memWriteM),
    .byteMaskM     (byteMaskM),
    .wbW           (wbW),
    .flags         (flags),
    .pcWrPending   (pcWrPending)
  );

  // ==========================================================================
  // Row builders, expectations from the ISA rules
  // ==========================================================================
  function automatic row_t nopRow();
    row_t r;
    r          = '0;
    r.instr    = NopInstr;
    r.aluFlags = 4'($urandom);
    r.offset   = 2'($urandom);
    return r;
  endfunction

  function automatic row_t dpRow(condCode_t cond, aluOp_t op, logic sBit, logic immForm,
                                 logic [3:0] rd);
    row_t r;
    r             = nopRow();
    r.instr       = {cond, 2'b00, immForm, op, sBit, 4'h1, rd, immForm ? 12'h0FF : 12'h002};
    r.expAluCtrl  = op;
    r.expAluSrc   = immForm;
    r.expSetFlags = sBit;
    r.expRegWrite = !(op inside {aluTst, aluTeq, aluCmp, aluCmn});  // Compares write no Rd
    r.expPcSrc    = r.expRegWrite && (rd == 4'hF);
    return r;
  endfunction

  function automatic row_t memRow(condCode_t cond, logic load, logic byteAcc, logic up,
                                  logic regOff, logic [3:0] rd);
    row_t r;
    r             = nopRow();
    r.instr       = {cond, 2'b01, regOff, 1'b1, up, byteAcc, 1'b0, load, 4'h2, rd,
                     regOff ? 12'h003 : 12'h010};
    r.expDecode   = {!load, 1'b0, 2'b01};
    r.expAluSrc   = !regOff;
    r.expAluCtrl  = up ? aluAdd : aluSub;
    r.expRegWrite = load;
    r.expMemWrite = !load;
    r.expByte     = byteAcc;
    r.expPcSrc    = load && (rd == 4'hF);  // LDR into PC
    return r;
  endfunction

  function automatic row_t branchRow(condCode_t cond);
    row_t r;
    r            = nopRow();
    r.instr      = {cond, 3'b101, 1'b0, 24'h00_0010};
    r.expDecode  = 4'b0110;
    r.expAluSrc  = 1'b1;
    r.expAluCtrl = aluAdd;
    r.expBranch  = 1'b1;
    r.expPcSrc   = 1'b1;
    return r;
  endfunction

  function automatic row_t movsRow(logic [3:0] newFlags);
    row_t r;
    r          = dpRow(condAl, aluMov, 1'b1, 1'b1, 4'h7);
    r.aluFlags = newFlags;
    return r;
  endfunction

  // ARM condition table, pairs share a base test and cond[0] inverts
  function automatic logic condHolds(logic [3:0] cond, logic [3:0] f);
    logic base;
    case (cond[3:1])
      3'd0:    base = f[2];                         // Z
      3'd1:    base = f[1];                         // C
      3'd2:    base = f[3];                         // N
      3'd3:    base = f[0];                         // V
      3'd4:    base = f[1] && !f[2];
      3'd5:    base = (f[3] == f[0]);
      3'd6:    base = !f[2] && (f[3] == f[0]);
      default: base = 1'b1;
    endcase
    return (cond == 4'hE) ? 1'b1 : (base ^ cond[0]);
  endfunction

  function automatic logic [3:0] laneMask(row_t r, logic pass);
    if (!(r.expMemWrite && pass)) return 4'h0;
    return r.expByte ? (4'b0001 << r.offset) : 4'hF;
  endfunction

  function automatic row_t rowAt(slot_t s);
    return s.valid ? rows[s.idx] : '0;  // Empty stage acts as a cleared word
  endfunction

  task automatic buildTable();
    row_t r;
    int   c;
    int   lap;
    int   k;
    // Decode of each class
    rows.push_back(dpRow(condAl, aluAdd, 1'b0, 1'b0, 4'h1));
    rows.push_back(dpRow(condAl, aluSub, 1'b0, 1'b1, 4'h2));
    rows.push_back(dpRow(condAl, aluCmp, 1'b1, 1'b1, 4'h0));
    rows.push_back(dpRow(condAl, aluTst, 1'b1, 1'b0, 4'h0));
    rows.push_back(dpRow(condAl, aluMov, 1'b0, 1'b1, 4'hF));  // Writes PC
    rows.push_back(memRow(condAl, 1'b1, 1'b0, 1'b1, 1'b0, 4'h3));
    rows.push_back(memRow(condAl, 1'b1, 1'b1, 1'b0, 1'b1, 4'h4));
    rows.push_back(memRow(condAl, 1'b1, 1'b0, 1'b1, 1'b0, 4'hF));
    rows.push_back(branchRow(condAl));
    rows.push_back(nopRow());
    // All conditions, forwarded from Memory, Writeback or the register
    for (lap = 0; lap < 2; lap++) begin
      for (c = 0; c < 15; c++) begin
        rows.push_back(movsRow(4'($urandom)));
        repeat ((c + lap) % 3) rows.push_back(nopRow());
        rows.push_back(branchRow(condCode_t'(c)));
      end
    end
    // Store lanes
    for (k = 0; k < 4; k++) begin
      r        = memRow(condAl, 1'b0, 1'b1, 1'b1, 1'b0, 4'h3);
      r.offset = 2'(k);
      rows.push_back(r);
    end
    rows.push_back(memRow(condAl, 1'b0, 1'b0, 1'b0, 1'b1, 4'h3));
    rows.push_back(movsRow(4'b0100));                               // Z set
    rows.push_back(memRow(condNe, 1'b0, 1'b0, 1'b1, 1'b0, 4'h3));  // Fails
    rows.push_back(memRow(condEq, 1'b0, 1'b1, 1'b1, 1'b0, 4'h3));
    // Execute stall, then a full freeze
    rows.push_back(dpRow(condAl, aluAdd, 1'b0, 1'b0, 4'h6));
    r        = dpRow(condAl, aluOrr, 1'b0, 1'b1, 4'h8);
    r.stallE = 1'b1;
    rows.push_back(r);
    r.stallE = 1'b0;
    rows.push_back(r);                                              // Decode retried
    rows.push_back(memRow(condAl, 1'b0, 1'b1, 1'b1, 1'b0, 4'h2));
    r        = dpRow(condAl, aluEor, 1'b0, 1'b0, 4'hA);
    r.stallE = 1'b1;
    r.stallM = 1'b1;
    r.stallW = 1'b1;
    rows.push_back(r);
    r        = dpRow(condAl, aluEor, 1'b0, 1'b0, 4'hA);
    rows.push_back(r);
    // Flushes
    r        = dpRow(condAl, aluMov, 1'b0, 1'b1, 4'h5);
    r.flushE = 1'b1;
    rows.push_back(r);
    rows.push_back(dpRow(condAl, aluAdd, 1'b0, 1'b1, 4'h9));
    rows.push_back(nopRow());
    r        = nopRow();
    r.flushW = 1'b1;                                                // Kills the ADD
    rows.push_back(r);
    rows.push_back(movsRow(4'b0011));
    rows.push_back(nopRow());
    rows.push_back(r);                                              // Kills the MOVS
    // Flag commit timing
    rows.push_back(movsRow(4'b1001));
    repeat (4) rows.push_back(nopRow());
    rows.push_back(dpRow(condAl, aluAdd, 1'b0, 1'b0, 4'h1));
    rows.push_back(dpRow(condVc, aluCmp, 1'b1, 1'b1, 4'h0));       // V set, skipped
    repeat (6) rows.push_back(nopRow());                            // Drain
  endtask

  // ==========================================================================
  // Stage model and checks
  // ==========================================================================
  task automatic expectEqual(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH %s at %0t: got 0x%h, expected 0x%h", name, $time, got, exp);
    end
  endtask

  task automatic applyRow(input row_t r);
    row_t eRow;
    eRow          = rowAt(eSlot);
    instrD        = r.instr;
    stallE        = r.stallE;
    flushE        = r.flushE;
    stallM        = r.stallM;
    stallW        = r.stallW;
    flushW        = r.flushW;
    aluFlagsE     = nzcv_t'(eRow.aluFlags);  // Datapath follows the Execute instruction
    aluResultLowE = eRow.offset;
  endtask

  task automatic evalExecute();
    row_t       eRow;
    row_t       mRow;
    row_t       wRow;
    logic [3:0] fwd;
    eRow = rowAt(eSlot);
    mRow = rowAt(mSlot);
    wRow = rowAt(wSlot);
    if (mSlot.pass && mRow.expSetFlags) begin
      fwd = mSlot.newFlags;                  // Youngest writer
    end else if (wSlot.pass && wRow.expSetFlags) begin
      fwd = wSlot.newFlags;
    end else begin
      fwd = expFlags;
    end
    eSlot.pass     = condHolds(eRow.instr[31:28], fwd);
    eSlot.newFlags = (eSlot.pass && eRow.expSetFlags) ? eRow.aluFlags : fwd;
  endtask

  task automatic checkOutputs(input row_t dRow);
    row_t eRow;
    row_t mRow;
    row_t wRow;
    logic expPending;
    eRow       = rowAt(eSlot);
    mRow       = rowAt(mSlot);
    wRow       = rowAt(wSlot);
    expPending = dRow.expPcSrc || eRow.expPcSrc || (mRow.expPcSrc && mSlot.pass);
    expectEqual("decodeD", decodeD, dRow.expDecode);
    expectEqual("aluControlE", aluControlE, eRow.expAluCtrl);
    expectEqual("aluSrcE", aluSrcE, eRow.expAluSrc);
    expectEqual("branchTakenE", branchTakenE, eRow.expBranch && eSlot.pass);
    expectEqual("memWriteM", memWriteM, mRow.expMemWrite && mSlot.pass);
    expectEqual("byteMaskM", byteMaskM, laneMask(mRow, mSlot.pass));
    expectEqual("wbW.regWrite", wbW.regWrite, wRow.expRegWrite && wSlot.pass);
    expectEqual("wbW.pcSrc", wbW.pcSrc, wRow.expPcSrc && wSlot.pass);
    expectEqual("flags", flags, expFlags);
    expectEqual("pcWrPending", pcWrPending, expPending);
  endtask

  // Register moves of the edge just passed, oldest stage first
  task automatic advanceModel(input row_t r, input int k);
    row_t wRow;
    wRow = rowAt(wSlot);
    if (wSlot.pass && wRow.expSetFlags && !r.stallW) begin
      expFlags = wSlot.newFlags;             // Commit in Writeback
    end
    if (!r.stallW) wSlot = r.flushW ? '0 : mSlot;
    if (!r.stallM) mSlot = eSlot;            // Memory has no flush
    if (!r.stallE) begin
      eSlot = '0;
      if (!r.flushE) begin
        eSlot.valid = 1'b1;
        eSlot.idx   = 8'(k);
      end
    end
  endtask

  // ==========================================================================
  // Run
  // ==========================================================================
  initial begin : watchdog
    wait (tableReady);
    #(rows.size() * 4 * ClkPeriod + 200);
    $display("Timeout: the run did not reach the end of the table in time");
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : stimulus
    int k;
    void'($urandom(46114));
    rstN          = 1'b0;
    instrD        = NopInstr;
    aluFlagsE     = '0;
    aluResultLowE = 2'b00;
    stallE        = 1'b0;
    flushE        = 1'b0;
    stallM        = 1'b0;
    stallW        = 1'b0;
    flushW        = 1'b0;
    eSlot         = '0;
    mSlot         = '0;
    wSlot         = '0;
    expFlags      = ResetFlags;
    checks        = 0;
    errors        = 0;
    tableReady    = 1'b0;
    buildTable();
    tableReady = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    #1;
    // Inactive outputs straight out of reset
    expectEqual("memWriteM", memWriteM, 1'b0);
    expectEqual("branchTakenE", branchTakenE, 1'b0);
    expectEqual("wbW.regWrite", wbW.regWrite, 1'b0);
    expectEqual("pcWrPending", pcWrPending, 1'b0);
    expectEqual("flags", flags, ResetFlags);
    @(negedge clk);
    for (k = 0; k < rows.size(); k++) begin
      applyRow(rows[k]);
      #1;
      evalExecute();
      checkOutputs(rows[k]);
      @(negedge clk);                        // Rising edge samples row k
      advanceModel(rows[k], k);
    end
    $display("Summary: %0d checks, %0d mismatches", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
logic/armIsaPkg.sv
logic/ctrlPkg.sv
logic/instrDecoder.sv
logic/condCheck.sv
logic/execStage.sv
logic/memWbStages.sv
logic/flagReg.sv
logic/ctrlTop.sv
tests/tbClock.sv
tests/ctrlTb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build ctrlTb with Verilator, run it and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module ctrlTb -Mdir obj_dir -f list.f
	-./obj_dir/VctrlTb > sim.log 2>&1
	@cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TESTS PASSED" sim.log; then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
